// ==== decode_stage.sv ====
`include "riscv_defines.svh"

module decode_stage import riscv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fetch_out_t  fetch_i,
    output reg_idx_t    rs1_o,
    output reg_idx_t    rs2_o,
    input  word_t       op1_i,
    input  word_t       op2_i,
    output decode_out_t decode_o
);
    word_t       instr;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    decode_out_t dec_next;

    // empty slot decodes as a nop
    assign instr  = fetch_i.valid ? fetch_i.instr : `NOP_INSTR;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    always_comb begin
        dec_next.valid    = fetch_i.valid;
        dec_next.opcode   = OP_OTHER;
        dec_next.rd       = instr[11:7];
        dec_next.rs1      = rs1_o;
        dec_next.rs2      = rs2_o;
        dec_next.op1      = op1_i;
        dec_next.op2      = op2_i;
        dec_next.imm      = '0;
        dec_next.write_en = 1'b0;
        case (instr[6:0])
            OP_LUI: begin
                dec_next.opcode   = OP_LUI;
                dec_next.imm      = {instr[31:12], 12'b0};
                dec_next.write_en = 1'b1;
            end
            OP_ADDI: begin
                if (funct3 == 3'b000) begin
                    dec_next.opcode   = OP_ADDI;
                    dec_next.imm      = {{20{instr[31]}}, instr[31:20]};
                    dec_next.write_en = 1'b1;
                end
            end
            OP_ADD: begin
                if ((funct3 == 3'b000) && (funct7 == 7'b0)) begin
                    dec_next.opcode   = OP_ADD;
                    dec_next.write_en = 1'b1;
                end
            end
            OP_STORE: begin
                // word stores only
                if (funct3 == 3'b010) begin
                    dec_next.opcode = OP_STORE;
                    dec_next.imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_o.valid    <= 1'b0;
            decode_o.write_en <= 1'b0;
        end else begin
            decode_o <= dec_next;
        end
    end

    store_no_write_a: assert property (@(posedge clk) disable iff (reset)
        decode_o.valid |-> !(decode_o.write_en && (decode_o.opcode == OP_STORE)));
endmodule

// ==== edge_pulse.sv ====
module edge_pulse (
    input  logic clk,
    input  logic reset,
    input  logic level_i,
    output logic pulse_o
);
    logic level_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            level_q <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            level_q <= level_i;
            // high for one cycle on a low to high change
            pulse_o <= level_i & ~level_q;
        end
    end
endmodule

// ==== execute_stage.sv ====
module execute_stage import riscv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  decode_out_t decode_i,
    input  exec_out_t   wb_i,
    output exec_out_t   exec_o
);
    logic      wb_hit;
    word_t     src_a;
    word_t     src_b;
    exec_out_t exec_next;

    assign wb_hit = wb_i.valid && wb_i.write_en && (wb_i.rd != '0);

    // forward from the instruction one ahead
    assign src_a = (wb_hit && (wb_i.rd == decode_i.rs1)) ? wb_i.result : decode_i.op1;
    assign src_b = (wb_hit && (wb_i.rd == decode_i.rs2)) ? wb_i.result : decode_i.op2;

    always_comb begin
        exec_next.valid      = decode_i.valid;
        exec_next.rd         = decode_i.rd;
        exec_next.write_en   = decode_i.write_en;
        exec_next.is_store   = (decode_i.opcode == OP_STORE);
        exec_next.store_data = src_b;
        case (decode_i.opcode)
            OP_LUI:   exec_next.result = decode_i.imm;
            OP_ADDI:  exec_next.result = src_a + decode_i.imm;
            OP_ADD:   exec_next.result = src_a + src_b;
            // effective address
            OP_STORE: exec_next.result = src_a + decode_i.imm;
            default:  exec_next.result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_o.valid    <= 1'b0;
            exec_o.write_en <= 1'b0;
            exec_o.is_store <= 1'b0;
        end else begin
            exec_o <= exec_next;
        end
    end
endmodule

// ==== fetch_unit.sv ====
`include "riscv_defines.svh"

module fetch_unit import riscv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_i,
    input  logic       run_en_i,
    input  word_t      initial_pc_i,
    output logic       imem_req_o,
    output word_t      imem_addr_o,
    input  word_t      imem_rdata_i,
    output fetch_out_t fetch_o
);
    word_t pc;
    word_t req_pc;
    logic  req_pending;

    // one request per cycle while running
    assign imem_req_o  = run_en_i;
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            req_pending <= 1'b0;
        end else begin
            if (start_i) begin
                pc <= initial_pc_i;
            end else if (run_en_i) begin
                pc <= pc + `INSTR_STEP;
            end
            req_pending <= imem_req_o;
        end
    end

    always_ff @(posedge clk) begin
        req_pc <= pc;
    end

    // bram data returns one cycle after the request
    assign fetch_o = '{valid: req_pending, pc: req_pc, instr: imem_rdata_i};
endmodule

// ==== list.f ====
+incdir+.
riscv_pkg.sv
edge_pulse.sv
run_control.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
store_unit.sv
riscv_core_top.sv
tb_clock.sv
tb_top.sv

// ==== reg_file.sv ====
`include "riscv_defines.svh"

module reg_file import riscv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_idx_t  rs1_i,
    input  reg_idx_t  rs2_i,
    output word_t     op1_o,
    output word_t     op2_o,
    input  exec_out_t wb_i
);
    word_t regs [`NUM_REGS];
    logic  wr_en;

    assign wr_en = wb_i.valid && wb_i.write_en && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    // x0 reads zero, a same-cycle write is passed through
    always_comb begin
        if (rs1_i == '0) begin
            op1_o = '0;
        end else if (wr_en && (wb_i.rd == rs1_i)) begin
            op1_o = wb_i.result;
        end else begin
            op1_o = regs[rs1_i];
        end
        if (rs2_i == '0) begin
            op2_o = '0;
        end else if (wr_en && (wb_i.rd == rs2_i)) begin
            op2_o = wb_i.result;
        end else begin
            op2_o = regs[rs2_i];
        end
    end
endmodule

// ==== riscv_core_top.sv ====
`include "riscv_defines.svh"

module riscv_core_top import riscv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      ctrl_i,
    input  word_t      mem_offset_i,
    input  word_t      initial_pc_i,
    input  word_t      success_code_i,
    output logic       imem_req_o,
    output word_t      imem_addr_o,
    input  word_t      imem_rdata_i,
    output logic [3:0] dmem_we_o,
    output word_t      dmem_addr_o,
    output word_t      dmem_wdata_o,
    output word_t      final_value_o,
    output word_t      cycle_count_o,
    output logic       stop_o
);
    logic        start_pulse;
    logic        run_en;
    fetch_out_t  fetch_bus;
    decode_out_t decode_bus;
    exec_out_t   exec_bus;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rf_op1;
    word_t       rf_op2;

    // bit 0 of the control word starts a run
    edge_pulse u_edge_pulse (
        .clk     (clk),
        .reset   (reset),
        .level_i (ctrl_i[0]),
        .pulse_o (start_pulse)
    );

    run_control u_run_control (
        .clk            (clk),
        .reset          (reset),
        .start_i        (start_pulse),
        .final_value_i  (final_value_o),
        .success_code_i (success_code_i),
        .run_en_o       (run_en),
        .cycle_count_o  (cycle_count_o),
        .stop_o         (stop_o)
    );

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_pulse),
        .run_en_i     (run_en),
        .initial_pc_i (initial_pc_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .fetch_o      (fetch_bus)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .rs1_i (rs1_idx),
        .rs2_i (rs2_idx),
        .op1_o (rf_op1),
        .op2_o (rf_op2),
        .wb_i  (exec_bus)
    );

    decode_stage u_decode_stage (
        .clk      (clk),
        .reset    (reset),
        .fetch_i  (fetch_bus),
        .rs1_o    (rs1_idx),
        .rs2_o    (rs2_idx),
        .op1_i    (rf_op1),
        .op2_i    (rf_op2),
        .decode_o (decode_bus)
    );

    // execute register doubles as write-back and forwarding source
    execute_stage u_execute_stage (
        .clk      (clk),
        .reset    (reset),
        .decode_i (decode_bus),
        .wb_i     (exec_bus),
        .exec_o   (exec_bus)
    );

    store_unit u_store_unit (
        .clk           (clk),
        .reset         (reset),
        .exec_i        (exec_bus),
        .mem_offset_i  (mem_offset_i),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .final_value_o (final_value_o)
    );
endmodule

// ==== riscv_defines.svh ====
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// datapath and address width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// byte step between consecutive fetches
`define INSTR_STEP 32'd4

// matching cycles of final value before the stop flag
`define STOP_HOLD_CYCLES 32'd30

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== riscv_pkg.sv ====
`include "riscv_defines.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes the core executes, all else retires as a no-op
    typedef enum logic [6:0] {
        OP_OTHER = 7'b0000000,
        OP_LUI   = 7'b0110111,
        OP_ADDI  = 7'b0010011,
        OP_ADD   = 7'b0110011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // instruction word paired with its pc
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_out_t;

    typedef struct packed {
        logic     valid;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    op1;
        word_t    op2;
        word_t    imm;
        logic     write_en;
    } decode_out_t;

    // result is the effective address for stores
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     write_en;
        word_t    result;
        logic     is_store;
        word_t    store_data;
    } exec_out_t;

endpackage

// ==== run_control.sv ====
`include "riscv_defines.svh"

module run_control import riscv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start_i,
    input  word_t final_value_i,
    input  word_t success_code_i,
    output logic  run_en_o,
    output word_t cycle_count_o,
    output logic  stop_o
);
    word_t hold_cnt;
    logic  code_match;

    assign code_match = (final_value_i == success_code_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            run_en_o      <= 1'b0;
            cycle_count_o <= '0;
            hold_cnt      <= '0;
            stop_o        <= 1'b0;
        end else begin
            if (start_i) begin
                run_en_o      <= 1'b1;
                cycle_count_o <= '0;
            end else if (run_en_o) begin
                cycle_count_o <= cycle_count_o + 1'b1;
            end
            // saturates once the hold target is reached
            if (code_match && (hold_cnt < `STOP_HOLD_CYCLES)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            if (hold_cnt == `STOP_HOLD_CYCLES) begin
                stop_o <= 1'b1;
            end
        end
    end

    // stop is sticky until the next reset
    stop_sticky_a: assert property (@(posedge clk) disable iff (reset)
        stop_o |=> stop_o);
endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f list.f -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_top_sim | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== store_unit.sv ====
module store_unit import riscv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  exec_out_t  exec_i,
    input  word_t      mem_offset_i,
    output logic [3:0] dmem_we_o,
    output word_t      dmem_addr_o,
    output word_t      dmem_wdata_o,
    output word_t      final_value_o
);
    logic store_valid;

    assign store_valid = exec_i.valid && exec_i.is_store;

    // full word writes only
    assign dmem_we_o    = store_valid ? 4'hf : 4'h0;
    // bram is addressed relative to the offset
    assign dmem_addr_o  = exec_i.result - mem_offset_i;
    assign dmem_wdata_o = exec_i.store_data;

    // success mailbox sits at the base of data memory
    always_ff @(posedge clk) begin
        if (reset) begin
            final_value_o <= '0;
        end else if (store_valid && (exec_i.result == mem_offset_i)) begin
            final_value_o <= exec_i.store_data;
        end
    end
endmodule

// ==== tb_clock.sv ====
module tb_clock (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end
endmodule

// ==== tb_top.sv ====
`include "riscv_defines.svh"

module tb_top import riscv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t MEM_OFFSET = 32'h0000_1000;
    localparam word_t INIT_PC    = 32'h0000_0080;
    localparam int    PROG_MAX   = 64;
    localparam int    NUM_TESTS  = 5;

    // one expected data write, address already relative to the offset
    typedef struct packed {
        word_t addr;
        word_t data;
    } wr_exp_t;

    logic       clk;
    logic       reset;
    word_t      ctrl;
    word_t      mem_offset;
    word_t      init_pc;
    word_t      success_code;
    logic       imem_req;
    word_t      imem_addr;
    word_t      imem_rdata = '0;
    logic [3:0] dmem_we;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    word_t      final_value;
    word_t      cycle_count;
    logic       stop;

    word_t   imem [PROG_MAX];
    word_t   ref_regs [`NUM_REGS];
    wr_exp_t exp_q [$];
    wr_exp_t wr_head;
    int      prog_len;
    int      exp_count;
    int      timeout_limit;
    word_t   success_val;
    int      wr_idx;
    int      match_cnt;
    int      cycle_cnt = 0;
    int      err_cnt [1:NUM_TESTS] = '{default: 0};
    int      err_total;
    logic    req_q;
    word_t   addr_q;
    word_t   count_q;
    logic    first_edge_done = 1'b0;

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    riscv_core_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .ctrl_i         (ctrl),
        .mem_offset_i   (mem_offset),
        .initial_pc_i   (init_pc),
        .success_code_i (success_code),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .dmem_we_o      (dmem_we),
        .dmem_addr_o    (dmem_addr),
        .dmem_wdata_o   (dmem_wdata),
        .final_value_o  (final_value),
        .cycle_count_o  (cycle_count),
        .stop_o         (stop)
    );

    // outside the program every fetch sees a nop
    function automatic word_t read_imem(input word_t addr);
        word_t idx;
        idx = (addr - INIT_PC) >> 2;
        if ((addr >= INIT_PC) && (idx < PROG_MAX)) begin
            return imem[idx[5:0]];
        end
        return `NOP_INSTR;
    endfunction

    // instruction bram, one cycle read latency
    always @(posedge clk) begin
        if (imem_req) begin
            imem_rdata <= read_imem(imem_addr);
        end
    end

    task automatic put_instr(input word_t instr);
        imem[prog_len[5:0]] = instr;
        prog_len++;
    endtask

    task automatic emit_lui(input reg_idx_t rd, input logic [19:0] imm);
        put_instr({imm, rd, 7'b0110111});
        if (rd != '0) begin
            ref_regs[rd] = {imm, 12'b0};
        end
    endtask

    task automatic emit_addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        put_instr({imm, rs1, 3'b000, rd, 7'b0010011});
        if (rd != '0) begin
            ref_regs[rd] = ref_regs[rs1] + {{20{imm[11]}}, imm};
        end
    endtask

    task automatic emit_add(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        put_instr({7'b0, rs2, rs1, 3'b000, rd, 7'b0110011});
        if (rd != '0) begin
            ref_regs[rd] = ref_regs[rs1] + ref_regs[rs2];
        end
    endtask

    task automatic emit_sw(input reg_idx_t rs2, input reg_idx_t rs1, input logic [11:0] imm);
        wr_exp_t w;
        put_instr({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
        w.addr = ref_regs[rs1] + {{20{imm[11]}}, imm} - MEM_OFFSET;
        w.data = ref_regs[rs2];
        exp_q.push_back(w);
    endtask

    task automatic build_program();
        word_t rnd;
        word_t tmp;
        prog_len = 0;
        foreach (imem[i]) begin
            imem[i] = `NOP_INSTR;
        end
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        success_val = $urandom() | 32'h1;
        // x10 points at the data region
        emit_lui(5'd10, 20'h00001);
        rnd = $urandom();
        emit_lui(5'd1, rnd[19:0]);
        rnd = $urandom();
        emit_addi(5'd1, 5'd1, rnd[11:0]);
        rnd = $urandom();
        emit_addi(5'd2, 5'd1, rnd[11:0]);
        // one apart on x1, back to back on x2
        emit_add(5'd3, 5'd1, 5'd2);
        emit_sw(5'd3, 5'd10, 12'd4);
        emit_add(5'd4, 5'd3, 5'd3);
        rnd = $urandom();
        emit_addi(5'd5, 5'd0, rnd[11:0]);
        emit_add(5'd6, 5'd4, 5'd5);
        emit_sw(5'd6, 5'd10, 12'd8);
        emit_sw(5'd1, 5'd10, 12'd12);
        // illegal word with rd = x31 must leave x31 alone
        rnd = $urandom();
        emit_lui(5'd31, rnd[19:0]);
        put_instr(32'hffff_ffff);
        emit_sw(5'd31, 5'd10, 12'd16);
        // x0 as destination
        emit_addi(5'd0, 5'd1, 12'd5);
        emit_sw(5'd0, 5'd10, 12'd20);
        // forwarded base with a negative offset
        emit_addi(5'd11, 5'd10, 12'd32);
        emit_sw(5'd2, 5'd11, 12'hffc);
        tmp = success_val + 32'h800;
        emit_lui(5'd7, tmp[31:12]);
        emit_addi(5'd7, 5'd7, success_val[11:0]);
        emit_sw(5'd7, 5'd10, 12'd0);
        exp_count = exp_q.size();
    endtask

    always @(posedge clk) begin
        first_edge_done <= 1'b1;
        if (reset) begin
            req_q     <= 1'b0;
            wr_idx    <= 0;
            wr_head   <= exp_q[0];
            match_cnt <= 0;
        end else begin
            req_q <= imem_req;
            if (dmem_we != 4'h0) begin
                wr_idx <= wr_idx + 1;
                if (wr_idx + 1 < exp_count) begin
                    wr_head <= exp_q[wr_idx + 1];
                end
            end
            if ((final_value == success_code) && (match_cnt <= `STOP_HOLD_CYCLES)) begin
                match_cnt <= match_cnt + 1;
            end
        end
        addr_q  <= imem_addr;
        count_q <= cycle_count;
    end

    // test 1
    quiet_a: assert property (@(posedge clk) first_edge_done && (reset || !ctrl[0])
        |-> (!imem_req && (dmem_we == 4'h0) && !stop && (cycle_count == '0)))
        else begin
            err_cnt[1]++;
            $display("Mismatch idle outputs: imem_req_o %h dmem_we_o %h stop_o %h cycle_count_o %h",
                $sampled(imem_req), $sampled(dmem_we), $sampled(stop), $sampled(cycle_count));
        end

    // test 2
    addr_first_a: assert property (@(posedge clk) disable iff (reset)
        imem_req && !req_q |-> imem_addr == INIT_PC)
        else begin
            err_cnt[2]++;
            $display("Mismatch imem_addr_o: got %h expected %h", $sampled(imem_addr), INIT_PC);
        end
    addr_step_a: assert property (@(posedge clk) disable iff (reset)
        imem_req && req_q |-> imem_addr == addr_q + `INSTR_STEP)
        else begin
            err_cnt[2]++;
            $display("Mismatch imem_addr_o: got %h expected %h",
                $sampled(imem_addr), $sampled(addr_q) + `INSTR_STEP);
        end
    count_first_a: assert property (@(posedge clk) disable iff (reset)
        imem_req && !req_q |-> cycle_count == '0)
        else begin
            err_cnt[2]++;
            $display("Mismatch cycle_count_o: got %h expected %h", $sampled(cycle_count), 32'h0);
        end
    count_step_a: assert property (@(posedge clk) disable iff (reset)
        imem_req && req_q |-> cycle_count == count_q + 1)
        else begin
            err_cnt[2]++;
            $display("Mismatch cycle_count_o: got %h expected %h",
                $sampled(cycle_count), $sampled(count_q) + 1);
        end

    // test 3
    extra_wr_a: assert property (@(posedge clk) disable iff (reset)
        dmem_we != 4'h0 |-> wr_idx < exp_count)
        else begin
            err_cnt[3]++;
            $display("unexpected data write at address %h after all stores", $sampled(dmem_addr));
        end
    wr_data_a: assert property (@(posedge clk) disable iff (reset)
        (dmem_we != 4'h0) && (wr_idx < exp_count) |-> dmem_wdata == wr_head.data)
        else begin
            err_cnt[3]++;
            $display("Mismatch dmem_wdata_o: got %h expected %h",
                $sampled(dmem_wdata), $sampled(wr_head.data));
        end

    // test 4
    wr_strobe_a: assert property (@(posedge clk) disable iff (reset)
        dmem_we != 4'h0 |-> dmem_we == 4'hf)
        else begin
            err_cnt[4]++;
            $display("Mismatch dmem_we_o: got %h expected %h", $sampled(dmem_we), 4'hf);
        end
    wr_addr_a: assert property (@(posedge clk) disable iff (reset)
        (dmem_we != 4'h0) && (wr_idx < exp_count) |-> dmem_addr == wr_head.addr)
        else begin
            err_cnt[4]++;
            $display("Mismatch dmem_addr_o: got %h expected %h",
                $sampled(dmem_addr), $sampled(wr_head.addr));
        end

    // test 5
    final_a: assert property (@(posedge clk) disable iff (reset)
        wr_idx == exp_count |-> final_value == success_code)
        else begin
            err_cnt[5]++;
            $display("Mismatch final_value_o: got %h expected %h",
                $sampled(final_value), $sampled(success_code));
        end
    stop_time_a: assert property (@(posedge clk) disable iff (reset)
        stop == (match_cnt > `STOP_HOLD_CYCLES))
        else begin
            err_cnt[5]++;
            $display("Mismatch stop_o: got %h expected %h",
                $sampled(stop), $sampled(match_cnt) > `STOP_HOLD_CYCLES);
        end
    stop_held_a: assert property (@(posedge clk) disable iff (reset) stop |=> stop)
        else begin
            err_cnt[5]++;
            $display("stop_o fell after it had risen");
        end

    task automatic report_test(input int num, input string name);
        $display("test %0d %-26s %s (%0d errors)", num, name,
            (err_cnt[num] == 0) ? "ok" : "failed", err_cnt[num]);
    endtask

    // run length bound
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: run did not complete within %0d cycles", timeout_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        ctrl         <= '0;
        mem_offset   <= '0;
        init_pc      <= '0;
        success_code <= '0;
        void'($urandom(32'h17f5aaed));
        build_program();
        timeout_limit = prog_len + `STOP_HOLD_CYCLES + 100;
        @(posedge clk);
        mem_offset   <= MEM_OFFSET;
        init_pc      <= INIT_PC;
        success_code <= success_val;
        while (reset) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        ctrl <= 32'h1;
        @(posedge clk);
        report_test(1, "idle outputs");
        while (wr_idx < exp_count) begin
            @(posedge clk);
        end
        @(posedge clk);
        report_test(2, "fetch and cycle count");
        report_test(3, "store data");
        report_test(4, "store strobe and address");
        while (!stop) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        report_test(5, "success and stop");
        err_total = 0;
        foreach (err_cnt[i]) begin
            err_total += err_cnt[i];
        end
        $display("tests %0d, stores %0d, errors %0d", NUM_TESTS, wr_idx, err_total);
        if (err_total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule
